// ==== bench/imem_model.sv ====
`timescale 1ns/1ps

module imem_model (
  input  logic            clock,
  input  logic            reset,
  input  logic            mem_valid,
  input  itim_pkg::addr_t mem_addr,
  output logic            mem_ready,
  output itim_pkg::word_t mem_rdata,
  output logic [31:0]     fetch_count
);

  itim_pkg::addr_t pending_addr;
  logic [2:0]      wait_left;
  logic            busy;

  // upper half of a word at an odd word address starts a 32-bit instruction.
  function automatic itim_pkg::word_t word_at(input itim_pkg::addr_t a);
    return {a[15:2], a[2], 1'b1, a[31:18] ^ a[15:2], a[17:16] ^ a[3:2]};
  endfunction

  initial begin
    void'($urandom(75483));
  end

  always @(posedge clock) begin
    if (!reset) begin
      mem_ready <= 1'b0;
      mem_rdata <= '0;
      pending_addr <= '0;
      wait_left <= '0;
      busy <= 1'b0;
      fetch_count <= '0;
    end else begin
      mem_ready <= 1'b0;
      if (mem_valid) begin
        pending_addr <= mem_addr;
        wait_left <= 3'(1 + ($urandom % 4));  // reply after 1 to 4 cycles.
        busy <= 1'b1;
        fetch_count <= fetch_count + 32'd1;
      end else if (busy) begin
        if (wait_left == 3'd1) begin
          mem_ready <= 1'b1;
          mem_rdata <= word_at(pending_addr);
          busy <= 1'b0;
        end else begin
          wait_left <= wait_left - 3'd1;
        end
      end
    end
  end

endmodule

// ==== bench/itim_tb.sv ====
`timescale 1ns/1ps

module itim_tb;

  localparam int depth = 16;
  localparam int num_tests = 23;
  localparam int timeout_cycles = num_tests * 40;

  // ****************************************
  // request table {address, fence, fetches}
  // ****************************************

  localparam logic [34:0] test_table [num_tests] = '{
    {32'h0000_1000, 1'b0, 2'd1},  // cold aligned fetch.
    {32'h0000_1000, 1'b0, 2'd0},
    {32'h0000_1002, 1'b0, 2'd0},  // compressed low half.
    {32'h0000_1006, 1'b0, 2'd2},
    {32'h0000_1006, 1'b0, 2'd0},
    {32'h0000_100e, 1'b0, 2'd2},  // crosses a line boundary.
    {32'h0000_100e, 1'b0, 2'd0},
    {32'h0000_1012, 1'b0, 2'd0},
    {32'h0000_101a, 1'b0, 2'd1},
    {32'h0000_2000, 1'b0, 2'd1},  // outside the window.
    {32'h0000_2000, 1'b0, 2'd1},
    {32'h0000_2006, 1'b0, 2'd2},
    {32'h0000_13fe, 1'b0, 2'd2},  // second word past the window top.
    {32'h0000_13fe, 1'b0, 2'd1},
    {32'h0000_0000, 1'b1, 2'd0},  // fence.
    {32'h0000_1000, 1'b0, 2'd1},
    {32'h0000_1006, 1'b0, 2'd2},
    {32'h0000_1100, 1'b0, 2'd1},  // same line index, other tag.
    {32'h0000_1000, 1'b0, 2'd1},
    {32'h0000_1100, 1'b0, 2'd1},
    {32'h0000_1104, 1'b0, 2'd1},
    {32'h0000_1004, 1'b0, 2'd1},
    {32'h0000_1000, 1'b0, 2'd1}
  };

  logic            clock;
  logic            reset;
  logic            req_valid;
  itim_pkg::addr_t req_addr;
  logic            req_fence;
  logic            resp_ready;
  itim_pkg::word_t resp_rdata;
  logic            mem_valid;
  itim_pkg::addr_t mem_addr;
  logic            mem_ready;
  itim_pkg::word_t mem_rdata;
  logic [31:0]     fetch_count;

  int              error_count = 0;
  int              cycle_count = 0;
  int              errors_before;
  int              latency;
  logic [31:0]     start_fetches;
  logic            got_resp;
  itim_pkg::word_t rdata;
  logic [34:0]     entry;

  itim #(
    .itim_depth(depth),
    .itim_width(4),
    .itim_base(32'h0000_1000),
    .itim_top(32'h0000_1400)
  ) dut0 (
    .clock(clock),
    .reset(reset),
    .req_valid(req_valid),
    .req_addr(req_addr),
    .req_fence(req_fence),
    .resp_ready(resp_ready),
    .resp_rdata(resp_rdata),
    .mem_valid(mem_valid),
    .mem_addr(mem_addr),
    .mem_ready(mem_ready),
    .mem_rdata(mem_rdata)
  );

  imem_model mem0 (
    .clock(clock),
    .reset(reset),
    .mem_valid(mem_valid),
    .mem_addr(mem_addr),
    .mem_ready(mem_ready),
    .mem_rdata(mem_rdata),
    .fetch_count(fetch_count)
  );

  always #4 clock = ~clock;

  // halfword fetch keeps the upper half only for a 32-bit instruction.
  function automatic itim_pkg::word_t expected_parcel(input itim_pkg::addr_t a);
    itim_pkg::word_t w1;
    itim_pkg::word_t w2;
    itim_pkg::half_t low;
    w1 = mem0.word_at({a[31:2], 2'b00});
    w2 = mem0.word_at({a[31:2], 2'b00} + 32'd4);
    low = w1[31:16];
    if (!a[1]) begin
      return w1;
    end
    if (low[1:0] == itim_pkg::full_len_code) begin
      return {w2[15:0], low};
    end
    return {16'h0000, low};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == timeout_cycles) begin
      $display("timeout: the DUT gave no response within %0d cycles", timeout_cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    clock = 1'b0;
    reset = 1'b0;
    req_valid = 1'b0;
    req_addr = '0;
    req_fence = 1'b0;
    repeat (3) @(negedge clock);
    reset = 1'b1;

    for (int i = 0; i < num_tests; i++) begin
      entry = test_table[i];
      errors_before = error_count;
      @(negedge clock);
      req_valid = 1'b1;
      req_addr = entry[34:3];
      req_fence = entry[2];
      start_fetches = fetch_count;
      latency = 0;
      got_resp = 1'b0;
      while (!got_resp) begin
        @(negedge clock);
        req_valid = 1'b0;
        req_fence = 1'b0;
        latency++;
        if (resp_ready) begin
          got_resp = 1'b1;
          rdata = resp_rdata;
        end
      end

      // ****************************************
      // compare against the table
      // ****************************************
      check_value("fetch_count", fetch_count - start_fetches, 32'(entry[1:0]));
      if (entry[2]) begin
        check_value("resp_rdata", rdata, 32'h0);
        check_value("latency", 32'(latency), 32'(depth + 1));
      end else begin
        check_value("resp_rdata", rdata, expected_parcel(entry[34:3]));
        if (entry[1:0] == 2'd0) begin
          check_value("latency", 32'(latency), 32'd1);  // hit answers next cycle.
        end
      end
      $display("test %0d addr %h fence %0d latency %0d: %s", i, entry[34:3], entry[2],
               latency, (error_count == errors_before) ? "ok" : "FAILED");
    end

    $display("tests %0d, errors %0d", num_tests, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== common/itim_pkg.sv ====
package itim_pkg;

  // ****************************************
  // vector types
  // ****************************************

  typedef logic [31:0] addr_t;  // byte address.
  typedef logic [31:0] word_t;  // instruction memory word.
  typedef logic [15:0] half_t;  // half of a fetch parcel.

  // ****************************************
  // controller states
  // ****************************************

  // hit waits for a request, miss states fill a bank,
  // load states fetch outside the window without storing.
  typedef enum logic [2:0] {
    st_hit,
    st_miss1,
    st_miss2,
    st_load1,
    st_load2,
    st_fence
  } itim_state_t;

  // two low bits of a halfword that starts a 32-bit instruction.
  localparam logic [1:0] full_len_code = 2'b11;

endpackage

// ==== itim.f ====
common/itim_pkg.sv
itim/itim_ram.sv
itim/itim_lookup.sv
itim/itim_align.sv
itim/itim_ctrl.sv
itim/itim.sv
bench/imem_model.sv
bench/itim_tb.sv

// ==== itim/itim.sv ====
`timescale 1ns/1ps

module itim #(
  parameter int itim_depth = 16,
  parameter int itim_width = 4,
  parameter itim_pkg::addr_t itim_base = 32'h0000_0000,
  parameter itim_pkg::addr_t itim_top = 32'h0000_1000
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            req_valid,
  input  itim_pkg::addr_t req_addr,
  input  logic            req_fence,
  output logic            resp_ready,
  output itim_pkg::word_t resp_rdata,
  output logic            mem_valid,
  output itim_pkg::addr_t mem_addr,
  input  logic            mem_ready,
  input  itim_pkg::word_t mem_rdata
);

  localparam int index_w = $clog2(itim_depth);
  localparam int offset_w = $clog2(itim_width);
  localparam int tag_w = 30 - index_w - offset_w;
  localparam int entry_w = 1 + tag_w + 32;  // lock, tag, data.

  logic [itim_width-1:0][index_w-1:0] read_index;
  logic [itim_width-1:0][entry_w-1:0] read_entry;
  logic [itim_width-1:0]              write_en;
  logic [index_w-1:0]                 write_index;
  logic [entry_w-1:0]                 write_entry;
  logic                               req_active;
  logic                               fence_req;
  itim_pkg::addr_t                    addr1;
  itim_pkg::addr_t                    addr2;
  logic                               odd_half;
  logic                               hit1;
  logic                               hit2;
  logic                               in_window1;
  logic                               in_window2;
  itim_pkg::word_t                    data1;
  itim_pkg::word_t                    data2;
  itim_pkg::word_t                    low_word;
  itim_pkg::word_t                    high_word;
  itim_pkg::word_t                    parcel;
  logic                               parcel_full;

  // ****************************************
  // one bank per word of a line
  // ****************************************

  for (genvar i = 0; i < itim_width; i++) begin : g_bank
    itim_ram #(
      .itim_depth(itim_depth),
      .entry_w(entry_w)
    ) ram0 (
      .clock(clock),
      .write_en(write_en[i]),
      .write_index(write_index),
      .write_entry(write_entry),
      .read_index(read_index[i]),
      .read_entry(read_entry[i])
    );
  end

  itim_lookup #(
    .itim_depth(itim_depth),
    .itim_width(itim_width),
    .itim_base(itim_base),
    .itim_top(itim_top)
  ) lookup0 (
    .clock(clock),
    .reset(reset),
    .req_valid(req_valid),
    .req_addr(req_addr),
    .req_fence(req_fence),
    .read_index(read_index),
    .read_entry(read_entry),
    .req_active(req_active),
    .fence_req(fence_req),
    .addr1(addr1),
    .addr2(addr2),
    .odd_half(odd_half),
    .hit1(hit1),
    .hit2(hit2),
    .in_window1(in_window1),
    .in_window2(in_window2),
    .data1(data1),
    .data2(data2)
  );

  itim_align align0 (
    .low_word(low_word),
    .high_word(high_word),
    .odd_half(odd_half),
    .parcel(parcel),
    .parcel_full(parcel_full)
  );

  itim_ctrl #(
    .itim_depth(itim_depth),
    .itim_width(itim_width)
  ) ctrl0 (
    .clock(clock),
    .reset(reset),
    .req_active(req_active),
    .fence_req(fence_req),
    .addr1(addr1),
    .addr2(addr2),
    .odd_half(odd_half),
    .hit1(hit1),
    .hit2(hit2),
    .in_window1(in_window1),
    .in_window2(in_window2),
    .data1(data1),
    .data2(data2),
    .mem_valid(mem_valid),
    .mem_addr(mem_addr),
    .mem_ready(mem_ready),
    .mem_rdata(mem_rdata),
    .low_word(low_word),
    .high_word(high_word),
    .parcel(parcel),
    .parcel_full(parcel_full),
    .write_en(write_en),
    .write_index(write_index),
    .write_entry(write_entry),
    .resp_ready(resp_ready),
    .resp_rdata(resp_rdata)
  );

endmodule

// ==== itim/itim_align.sv ====
`timescale 1ns/1ps

module itim_align (
  input  itim_pkg::word_t low_word,
  input  itim_pkg::word_t high_word,
  input  logic            odd_half,
  output itim_pkg::word_t parcel,
  output logic            parcel_full
);

  itim_pkg::half_t low_half;
  itim_pkg::half_t high_half;

  // a halfword fetch starts in the upper half of the first word.
  assign low_half = odd_half ? low_word[31:16] : low_word[15:0];

  assign parcel_full = (low_half[1:0] == itim_pkg::full_len_code);

  always_comb begin
    if (!odd_half) begin
      high_half = low_word[31:16];
    end else if (parcel_full) begin
      high_half = high_word[15:0];  // rest of a 32-bit instruction.
    end else begin
      high_half = '0;  // compressed, nothing follows.
    end
  end

  assign parcel = {high_half, low_half};

endmodule

// ==== itim/itim_ctrl.sv ====
`timescale 1ns/1ps

module itim_ctrl #(
  parameter int itim_depth = 16,
  parameter int itim_width = 4,
  localparam int index_w = $clog2(itim_depth),
  localparam int offset_w = $clog2(itim_width),
  localparam int tag_w = 30 - index_w - offset_w,
  localparam int entry_w = 1 + tag_w + 32
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  req_active,
  input  logic                  fence_req,
  input  itim_pkg::addr_t       addr1,
  input  itim_pkg::addr_t       addr2,
  input  logic                  odd_half,
  input  logic                  hit1,
  input  logic                  hit2,
  input  logic                  in_window1,
  input  logic                  in_window2,
  input  itim_pkg::word_t       data1,
  input  itim_pkg::word_t       data2,
  output logic                  mem_valid,
  output itim_pkg::addr_t       mem_addr,
  input  logic                  mem_ready,
  input  itim_pkg::word_t       mem_rdata,
  output itim_pkg::word_t       low_word,
  output itim_pkg::word_t       high_word,
  input  itim_pkg::word_t       parcel,
  input  logic                  parcel_full,
  output logic [itim_width-1:0] write_en,
  output logic [index_w-1:0]    write_index,
  output logic [entry_w-1:0]    write_entry,
  output logic                  resp_ready,
  output itim_pkg::word_t       resp_rdata
);

  itim_pkg::itim_state_t state;
  itim_pkg::itim_state_t state_next;
  logic [index_w-1:0]    fence_index;
  logic [index_w-1:0]    fence_next;
  itim_pkg::word_t       word1_q;
  logic                  fetch_second;
  logic                  need_second;
  logic                  word2_ok;

  // ****************************************
  // parcel sources
  // ****************************************

  assign need_second = odd_half && parcel_full;
  assign word2_ok = in_window2 && hit2;

  always_comb begin
    case (state)
      itim_pkg::st_hit: low_word = data1;
      itim_pkg::st_miss1, itim_pkg::st_load1: low_word = mem_rdata;
      default: low_word = word1_q;  // first word held while word 2 is fetched.
    endcase
  end

  assign high_word = (state == itim_pkg::st_miss2 || state == itim_pkg::st_load2) ?
                     mem_rdata : data2;

  assign mem_addr = fetch_second ? addr2 : addr1;

  // ****************************************
  // state machine
  // ****************************************

  always_comb begin
    state_next = state;
    fence_next = fence_index;
    mem_valid = 1'b0;
    fetch_second = 1'b0;
    write_en = '0;
    write_index = addr1[offset_w+index_w+1 -: index_w];
    write_entry = {1'b1, addr1[31 -: tag_w], mem_rdata};
    resp_ready = 1'b0;
    resp_rdata = '0;
    case (state)
      itim_pkg::st_hit: begin
        if (req_active) begin
          if (fence_req) begin
            state_next = itim_pkg::st_fence;
            fence_next = '0;
          end else if (!in_window1) begin
            mem_valid = 1'b1;
            state_next = itim_pkg::st_load1;
          end else if (!hit1) begin
            mem_valid = 1'b1;
            state_next = itim_pkg::st_miss1;
          end else if (need_second && !word2_ok) begin
            mem_valid = 1'b1;
            fetch_second = 1'b1;
            state_next = in_window2 ? itim_pkg::st_miss2 : itim_pkg::st_load2;
          end else begin
            resp_ready = 1'b1;
            resp_rdata = parcel;
          end
        end
      end
      itim_pkg::st_miss1, itim_pkg::st_load1: begin
        if (mem_ready) begin
          if (state == itim_pkg::st_miss1) begin
            write_en[addr1[offset_w+1:2]] = 1'b1;  // fill word 1.
          end
          if (need_second && !word2_ok) begin
            mem_valid = 1'b1;
            fetch_second = 1'b1;
            state_next = in_window2 ? itim_pkg::st_miss2 : itim_pkg::st_load2;
          end else begin
            resp_ready = 1'b1;
            resp_rdata = parcel;
            state_next = itim_pkg::st_hit;
          end
        end
      end
      itim_pkg::st_miss2, itim_pkg::st_load2: begin
        fetch_second = 1'b1;
        write_index = addr2[offset_w+index_w+1 -: index_w];
        write_entry = {1'b1, addr2[31 -: tag_w], mem_rdata};
        if (mem_ready) begin
          if (state == itim_pkg::st_miss2) begin
            write_en[addr2[offset_w+1:2]] = 1'b1;
          end
          resp_ready = 1'b1;
          resp_rdata = parcel;
          state_next = itim_pkg::st_hit;
        end
      end
      itim_pkg::st_fence: begin
        write_en = '1;  // clear the line in every bank.
        write_index = fence_index;
        write_entry = '0;
        if (&fence_index) begin
          resp_ready = 1'b1;
          state_next = itim_pkg::st_hit;
        end else begin
          fence_next = fence_index + 1'b1;
        end
      end
      default: begin
        state_next = itim_pkg::st_hit;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= itim_pkg::st_hit;
      fence_index <= '0;
    end else begin
      state <= state_next;
      fence_index <= fence_next;
    end
  end

  always_ff @(posedge clock) begin
    if (state == itim_pkg::st_hit || mem_ready) begin
      word1_q <= low_word;
    end
  end

  // a memory reply only arrives while a request is in flight.
  mem_reply_waits: assert property (@(posedge clock) disable iff (!reset)
    mem_ready |-> !(state inside {itim_pkg::st_hit, itim_pkg::st_fence}))
    else $error("itim_ctrl: memory reply outside a wait state");

  resp_ready_pulse: assert property (@(posedge clock) disable iff (!reset)
    resp_ready |=> !resp_ready)
    else $error("itim_ctrl: resp_ready held for two cycles");

endmodule

// ==== itim/itim_lookup.sv ====
`timescale 1ns/1ps

module itim_lookup #(
  parameter int itim_depth = 16,
  parameter int itim_width = 4,
  parameter itim_pkg::addr_t itim_base = 32'h0000_0000,
  parameter itim_pkg::addr_t itim_top = 32'h0000_1000,
  localparam int index_w = $clog2(itim_depth),
  localparam int offset_w = $clog2(itim_width),
  localparam int tag_w = 30 - index_w - offset_w,
  localparam int entry_w = 1 + tag_w + 32
) (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 req_valid,
  input  itim_pkg::addr_t                      req_addr,
  input  logic                                 req_fence,
  output logic [itim_width-1:0][index_w-1:0]   read_index,
  input  logic [itim_width-1:0][entry_w-1:0]   read_entry,
  output logic                                 req_active,
  output logic                                 fence_req,
  output itim_pkg::addr_t                      addr1,
  output itim_pkg::addr_t                      addr2,
  output logic                                 odd_half,
  output logic                                 hit1,
  output logic                                 hit2,
  output logic                                 in_window1,
  output logic                                 in_window2,
  output itim_pkg::word_t                      data1,
  output itim_pkg::word_t                      data2
);

  itim_pkg::addr_t    next1;
  itim_pkg::addr_t    next2;
  itim_pkg::addr_t    cur1;
  itim_pkg::addr_t    cur2;
  logic [entry_w-1:0] entry1;
  logic [entry_w-1:0] entry2;

  assign next1 = {req_addr[31:2], 2'b00};
  assign next2 = next1 + 32'd4;  // following word, may cross a line.

  // between requests the held address keeps the bank outputs steady.
  assign cur1 = req_valid ? next1 : addr1;
  assign cur2 = req_valid ? next2 : addr2;

  always_comb begin
    for (int b = 0; b < itim_width; b++) begin
      if (cur2[offset_w+1:2] == offset_w'(b)) begin
        read_index[b] = cur2[offset_w+index_w+1 -: index_w];
      end else begin
        read_index[b] = cur1[offset_w+index_w+1 -: index_w];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      req_active <= 1'b0;
      fence_req <= 1'b0;
    end else begin
      req_active <= req_valid;
      if (req_valid) begin
        fence_req <= req_fence;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid) begin
      addr1 <= next1;
      addr2 <= next2;
      odd_half <= req_addr[1];
    end
  end

  // ****************************************
  // tag compare
  // ****************************************

  assign entry1 = read_entry[addr1[offset_w+1:2]];
  assign entry2 = read_entry[addr2[offset_w+1:2]];

  assign hit1 = entry1[entry_w-1] && (entry1[entry_w-2 -: tag_w] == addr1[31 -: tag_w]);
  assign hit2 = entry2[entry_w-1] && (entry2[entry_w-2 -: tag_w] == addr2[31 -: tag_w]);
  assign data1 = entry1[31:0];
  assign data2 = entry2[31:0];

  assign in_window1 = (addr1 >= itim_base) && (addr1 < itim_top);
  assign in_window2 = (addr2 >= itim_base) && (addr2 < itim_top);

endmodule

// ==== itim/itim_ram.sv ====
`timescale 1ns/1ps

module itim_ram #(
  parameter int itim_depth = 16,
  parameter int entry_w = 59,
  localparam int index_w = $clog2(itim_depth)
) (
  input  logic               clock,
  input  logic               write_en,
  input  logic [index_w-1:0] write_index,
  input  logic [entry_w-1:0] write_entry,
  input  logic [index_w-1:0] read_index,
  output logic [entry_w-1:0] read_entry
);

  // entry is {lock, tag, data}, all clear at start.
  logic [entry_w-1:0] ram_array [itim_depth] = '{default: '0};
  logic [index_w-1:0] read_index_q;

  always_ff @(posedge clock) begin
    read_index_q <= read_index;
    if (write_en) begin
      ram_array[write_index] <= write_entry;
    end
  end

  assign read_entry = ram_array[read_index_q];  // one cycle read.

  write_index_known: assert property (@(posedge clock) write_en |-> !$isunknown(write_index))
    else $error("itim_ram: write with unknown index");

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the ITIM testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module itim_tb -f itim.f -o itim_sim

output=$(./obj_dir/itim_sim)
echo "$output"

if echo "$output" | grep -qx "Done: no errors"; then
  exit 0
else
  exit 1
fi
